//--- hdl/rob_settings.svh
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// rows in the buffer, power of two, 4 or more
`define ROB_DEPTH 8

// log2 of ROB_DEPTH
`define ROB_IDX_W 3

// alu0, alu1, mdu, lsu
`define ROB_NUM_FU 4

`endif

//--- hdl/rob_types_pkg.sv
`default_nettype none
`include "rob_settings.svh"

package rob_types_pkg;

    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;
    // row index in the upper bits, lane in bit 0
    typedef logic [`ROB_IDX_W:0]   rob_tag_t;
    typedef logic [31:0]           addr_t;
    typedef logic [4:0]            exc_code_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  is_ds;
        logic  is_branch;
    } uop_t;

    typedef struct packed {
        uop_t      uop;
        rob_tag_t  tag;
        logic      busy;
        logic      committed;
        logic      branch_taken;
        addr_t     branch_addr;
        logic      cause_exc;
        exc_code_t exception;
        addr_t     bad_vaddr;
    } rob_entry_t;

endpackage

`default_nettype wire

//--- hdl/rob_port_pkg.sv
`default_nettype none

package rob_port_pkg;
    import rob_types_pkg::*;

    typedef struct packed {
        uop_t uop0;
        uop_t uop1;
    } dispatch_pair_t;

    typedef struct packed {
        logic      finish;
        rob_tag_t  tag;
        logic      set_branch;
        logic      branch_taken;
        addr_t     branch_addr;
        logic      set_exc;
        exc_code_t exception;
        addr_t     bad_vaddr;
    } fu_report_t;

    typedef struct packed {
        rob_entry_t entry0;
        rob_entry_t entry1;
    } commit_pair_t;

    // one row of one lane, as seen by the bank
    typedef struct packed {
        logic      finish;
        logic      set_branch;
        logic      branch_taken;
        addr_t     branch_addr;
        logic      set_exc;
        exc_code_t exception;
        addr_t     bad_vaddr;
    } lane_update_t;

endpackage

`default_nettype wire

//--- hdl/rob_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "rob_settings.svh"

module rob_ctrl
    import rob_types_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              flush,
    input  wire              dispatch_valid,
    output logic             dispatch_ready,
    output rob_idx_t         dispatch_idx,
    output rob_idx_t         head_idx,
    input  wire rob_entry_t  head0,
    input  wire rob_entry_t  head1,
    output logic             commit_valid,
    input  wire              commit_ready,
    output logic [1:0]       commit_mask,
    output logic             alloc_en,
    output logic [1:0]       retire_en
);

    rob_idx_t head_q;
    rob_idx_t tail_q;
    rob_idx_t occupancy;
    logic     empty;
    logic     full;
    logic     ok0;
    logic     ok1;
    logic     fire;
    logic     done0;
    logic     done1;
    logic     head_adv;

    // distance wraps with the pointer width
    assign occupancy = tail_q - head_q;
    assign empty     = (occupancy == '0);
    // one row kept free so full and empty differ
    assign full      = (occupancy == rob_idx_t'(`ROB_DEPTH - 1));

    assign dispatch_ready = !full;
    assign dispatch_idx   = tail_q;
    assign head_idx       = head_q;
    assign alloc_en       = dispatch_valid && !full;

    // lane 0 waits for its delay slot in lane 1
    assign ok0 = head0.uop.valid && !head0.committed && !head0.busy
              && (!head1.uop.is_ds || !head1.busy);
    // lane 1 never passes lane 0
    assign ok1 = head1.uop.valid && !head1.committed && !head1.busy
              && (!head0.uop.valid || head0.committed || ok0);

    assign commit_valid = (ok0 || ok1) && !empty;
    assign commit_mask  = commit_valid ? {ok1, ok0} : 2'b00;
    assign fire         = commit_valid && commit_ready;
    assign retire_en    = fire ? commit_mask : 2'b00;

    assign done0    = !head0.uop.valid || head0.committed || retire_en[0];
    assign done1    = !head1.uop.valid || head1.committed || retire_en[1];
    assign head_adv = done0 && done1 && !empty;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (alloc_en) begin
                tail_q <= tail_q + 1'b1;
            end
            if (head_adv) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    // tail can't wrap around onto the head
    a_no_overrun: assert property (@(posedge clk) disable iff (rst || flush)
        (!empty && !head_adv) |=> !empty);

    // a freshly dispatched pair is still busy in its first head cycle
    a_no_commit_empty: assert property (@(posedge clk) disable iff (rst || flush)
        empty |=> !commit_valid);

endmodule

`default_nettype wire

//--- hdl/rob_finish_router.sv
`timescale 1ns/100ps
`default_nettype none
`include "rob_settings.svh"

module rob_finish_router
    import rob_types_pkg::*;
    import rob_port_pkg::*;
(
    input  wire fu_report_t fu_reports [`ROB_NUM_FU],
    output lane_update_t    upd0 [`ROB_DEPTH],
    output lane_update_t    upd1 [`ROB_DEPTH]
);

    rob_idx_t fu_row [`ROB_NUM_FU];
    logic     dup_tag;

    function automatic lane_update_t to_update(input fu_report_t rep);
        lane_update_t u;
        u.finish       = rep.finish;
        u.set_branch   = rep.set_branch;
        u.branch_taken = rep.branch_taken;
        u.branch_addr  = rep.branch_addr;
        u.set_exc      = rep.set_exc;
        u.exception    = rep.exception;
        u.bad_vaddr    = rep.bad_vaddr;
        return u;
    endfunction

    for (genvar f = 0; f < `ROB_NUM_FU; f++) begin : g_row
        assign fu_row[f] = fu_reports[f].tag[`ROB_IDX_W:1];
    end

    // tag bit 0 picks the lane
    always_comb begin
        for (int r = 0; r < `ROB_DEPTH; r++) begin
            upd0[r] = '0;
            upd1[r] = '0;
        end
        for (int f = 0; f < `ROB_NUM_FU; f++) begin
            if (fu_reports[f].finish && !fu_reports[f].tag[0]) begin
                upd0[fu_row[f]] = to_update(fu_reports[f]);
            end
            if (fu_reports[f].finish && fu_reports[f].tag[0]) begin
                upd1[fu_row[f]] = to_update(fu_reports[f]);
            end
        end
    end

    // units must never report the same instruction twice at once
    always_comb begin
        dup_tag = 1'b0;
        for (int a = 0; a < `ROB_NUM_FU; a++) begin
            for (int b = a + 1; b < `ROB_NUM_FU; b++) begin
                if (fu_reports[a].finish && fu_reports[b].finish
                        && fu_reports[a].tag == fu_reports[b].tag) begin
                    dup_tag = 1'b1;
                end
            end
        end
    end

    always_comb begin
        a_unique_tag: assert final (!dup_tag) else $error("two reports share one tag");
    end

endmodule

`default_nettype wire

//--- hdl/rob_lane_bank.sv
`timescale 1ns/100ps
`default_nettype none
`include "rob_settings.svh"

module rob_lane_bank
    import rob_types_pkg::*;
    import rob_port_pkg::*;
#(
    parameter logic lane = 1'b0
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               flush,
    input  wire               alloc_en,
    input  wire rob_idx_t     alloc_idx,
    input  wire uop_t         alloc_uop,
    input  wire lane_update_t upd [`ROB_DEPTH],
    input  wire rob_idx_t     head_idx,
    input  wire               retire,
    output rob_entry_t        head_entry
);

    rob_entry_t ents [`ROB_DEPTH];

    assign head_entry = ents[head_idx];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // only the state flags, payload is don't-care while invalid
            for (int r = 0; r < `ROB_DEPTH; r++) begin
                ents[r].uop.valid <= 1'b0;
                ents[r].busy      <= 1'b0;
                ents[r].committed <= 1'b0;
            end
        end else begin
            // completions from the router
            for (int r = 0; r < `ROB_DEPTH; r++) begin
                if (upd[r].finish) begin
                    ents[r].busy <= 1'b0;
                    if (upd[r].set_branch) begin
                        ents[r].branch_taken <= upd[r].branch_taken;
                        ents[r].branch_addr  <= upd[r].branch_addr;
                    end
                    if (upd[r].set_exc) begin
                        ents[r].cause_exc <= 1'b1;
                        ents[r].exception <= upd[r].exception;
                        ents[r].bad_vaddr <= upd[r].bad_vaddr;
                    end
                end
            end

            // new instruction at the tail row
            if (alloc_en) begin
                ents[alloc_idx].uop          <= alloc_uop;
                ents[alloc_idx].tag          <= {alloc_idx, lane};
                ents[alloc_idx].busy         <= alloc_uop.valid;
                ents[alloc_idx].committed    <= 1'b0;
                ents[alloc_idx].branch_taken <= 1'b0;
                ents[alloc_idx].branch_addr  <= '0;
                ents[alloc_idx].cause_exc    <= 1'b0;
                ents[alloc_idx].exception    <= '0;
                ents[alloc_idx].bad_vaddr    <= '0;
            end

            if (retire) begin
                ents[head_idx].committed <= 1'b1;
            end
        end
    end

    // a report only ever lands on an instruction still in flight
    for (genvar r = 0; r < `ROB_DEPTH; r++) begin : g_chk
        a_finish_busy: assert property (@(posedge clk) disable iff (rst || flush)
            upd[r].finish |-> ents[r].uop.valid && ents[r].busy);
    end

endmodule

`default_nettype wire

//--- hdl/rob_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "rob_settings.svh"

module rob_top
    import rob_types_pkg::*;
    import rob_port_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 flush,
    input  wire                 dispatch_valid,
    input  wire dispatch_pair_t dispatch,
    output logic                dispatch_ready,
    output rob_idx_t            dispatch_idx,
    input  wire fu_report_t     fu_reports [`ROB_NUM_FU],
    output logic                commit_valid,
    input  wire                 commit_ready,
    output commit_pair_t        commit,
    output logic [1:0]          commit_mask
);

    rob_idx_t     head_idx;
    rob_entry_t   head0;
    rob_entry_t   head1;
    logic         alloc_en;
    logic [1:0]   retire_en;
    lane_update_t upd0 [`ROB_DEPTH];
    lane_update_t upd1 [`ROB_DEPTH];

    assign commit.entry0 = head0;
    assign commit.entry1 = head1;

    rob_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_idx   (dispatch_idx),
        .head_idx       (head_idx),
        .head0          (head0),
        .head1          (head1),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit_mask    (commit_mask),
        .alloc_en       (alloc_en),
        .retire_en      (retire_en)
    );

    rob_finish_router u_router (
        .fu_reports (fu_reports),
        .upd0       (upd0),
        .upd1       (upd1)
    );

    rob_lane_bank #(.lane(1'b0)) u_bank0 (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .alloc_en   (alloc_en),
        .alloc_idx  (dispatch_idx),
        .alloc_uop  (dispatch.uop0),
        .upd        (upd0),
        .head_idx   (head_idx),
        .retire     (retire_en[0]),
        .head_entry (head0)
    );

    rob_lane_bank #(.lane(1'b1)) u_bank1 (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .alloc_en   (alloc_en),
        .alloc_idx  (dispatch_idx),
        .alloc_uop  (dispatch.uop1),
        .upd        (upd1),
        .head_idx   (head_idx),
        .retire     (retire_en[1]),
        .head_entry (head1)
    );

endmodule

`default_nettype wire

//--- bench/rob_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "rob_settings.svh"

module rob_tb
    import rob_types_pkg::*;
    import rob_port_pkg::*;
();

    localparam int NUM_TESTS  = 6;
    localparam int CLK_PERIOD = 8;

    logic           clk;
    logic           rst;
    logic           flush;
    logic           dispatch_valid;
    dispatch_pair_t dispatch;
    logic           dispatch_ready;
    rob_idx_t       dispatch_idx;
    fu_report_t     fu_reports [`ROB_NUM_FU];
    logic           commit_valid;
    logic           commit_ready;
    commit_pair_t   commit;
    logic [1:0]     commit_mask;

    // scoreboard of dispatched pairs, by row, in dispatch order
    uop_t     sb_uop0 [`ROB_DEPTH];
    uop_t     sb_uop1 [`ROB_DEPTH];
    rob_idx_t sb_rows [$];

    int errors;
    int checks;
    int tests_run;
    int test_errs;

    rob_top dut (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .dispatch_idx   (dispatch_idx),
        .fu_reports     (fu_reports),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit         (commit),
        .commit_mask    (commit_mask)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // every test fits easily in 200 cycles
    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("watchdog expired, the run did not complete in time");
        $display("tests failed");
        $finish;
    end

    task automatic check_bit(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %0s got %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic check_idx(input rob_idx_t got, input rob_idx_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %0s got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic check_entry(input rob_entry_t got, input rob_entry_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %0s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    function automatic uop_t rand_uop(input logic is_ds, input logic is_branch);
        uop_t u;
        u.valid     = 1'b1;
        u.pc        = addr_t'($urandom) & 32'hffff_fffc;
        u.is_ds     = is_ds;
        u.is_branch = is_branch;
        return u;
    endfunction

    // what a freshly allocated entry looks like once it has finished
    function automatic rob_entry_t expected_entry(input uop_t u, input rob_idx_t idx,
                                                  input logic lane);
        rob_entry_t e;
        e     = '0;
        e.uop = u;
        e.tag = {idx, lane};
        return e;
    endfunction

    function automatic fu_report_t finish_rep(input rob_idx_t idx, input logic lane);
        fu_report_t r;
        r        = '0;
        r.finish = 1'b1;
        r.tag    = {idx, lane};
        return r;
    endfunction

    task automatic send_pair(input uop_t u0, input uop_t u1);
        logic     rdy;
        rob_idx_t idx;
        @(posedge clk);
        dispatch_valid <= 1'b1;
        dispatch.uop0  <= u0;
        dispatch.uop1  <= u1;
        do begin
            @(negedge clk);
            rdy = dispatch_ready;
            idx = dispatch_idx;
            @(posedge clk);
        end while (!rdy);
        dispatch_valid <= 1'b0;
        sb_uop0[idx] = u0;
        sb_uop1[idx] = u1;
        sb_rows.push_back(idx);
    endtask

    // one-cycle pulse on a single completion port
    task automatic pulse_report(input int fu, input fu_report_t rep);
        @(posedge clk);
        fu_reports[fu] <= rep;
        @(posedge clk);
        fu_reports[fu] <= '0;
    endtask

    task automatic take_commit(input logic [1:0] mask_exp, input rob_entry_t e0,
                               input rob_entry_t e1, input int stall);
        commit_pair_t held;
        logic [1:0]   held_mask;
        @(negedge clk);
        while (!commit_valid) @(negedge clk);
        held      = commit;
        held_mask = commit_mask;
        // back-pressure, nothing may move
        repeat (stall) begin
            @(negedge clk);
            check_bit(commit_valid, 1'b1, "commit_valid under stall");
            check_bit(commit_mask == held_mask, 1'b1, "commit_mask under stall");
            check_entry(commit.entry0, held.entry0, "entry0 under stall");
            check_entry(commit.entry1, held.entry1, "entry1 under stall");
        end
        check_bit(commit_mask[0], mask_exp[0], "commit_mask[0]");
        check_bit(commit_mask[1], mask_exp[1], "commit_mask[1]");
        if (mask_exp[0]) check_entry(commit.entry0, e0, "committed entry0");
        if (mask_exp[1]) check_entry(commit.entry1, e1, "committed entry1");
        @(posedge clk);
        commit_ready <= 1'b1;
        @(posedge clk);
        commit_ready <= 1'b0;
    endtask

    task automatic flush_rob();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        sb_rows.delete();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %0s: %0s", name, (errors == test_errs) ? "ok" : "mismatch");
    endtask

    task automatic test_reset();
        test_errs = errors;
        @(negedge clk);
        check_bit(dispatch_ready, 1'b1, "dispatch_ready after reset");
        check_bit(commit_valid, 1'b0, "commit_valid after reset");
        check_idx(dispatch_idx, '0, "dispatch_idx after reset");
        finish_test("reset");
    endtask

    task automatic test_capacity();
        int accepted;
        test_errs = errors;
        accepted  = 0;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            @(negedge clk);
            if (!dispatch_ready) break;
            check_idx(dispatch_idx, rob_idx_t'(i), "dispatch_idx while filling");
            send_pair(rand_uop(1'b0, 1'b0), rand_uop(1'b0, 1'b0));
            accepted++;
        end
        @(negedge clk);
        check_bit(accepted == `ROB_DEPTH - 1, 1'b1, "pairs accepted before full");
        check_bit(dispatch_ready, 1'b0, "dispatch_ready when full");
        flush_rob();
        finish_test("capacity");
    endtask

    task automatic test_in_order();
        rob_idx_t r;
        test_errs = errors;
        for (int i = 0; i < 5; i++) begin
            send_pair(rand_uop(1'b0, 1'b0), rand_uop(1'b0, 1'b0));
        end
        // youngest finishes first
        for (int i = 4; i >= 0; i--) begin
            pulse_report(1, finish_rep(sb_rows[i], 1'b1));
            pulse_report(0, finish_rep(sb_rows[i], 1'b0));
        end
        while (sb_rows.size() > 0) begin
            r = sb_rows.pop_front();
            take_commit(2'b11, expected_entry(sb_uop0[r], r, 1'b0),
                        expected_entry(sb_uop1[r], r, 1'b1), $urandom_range(0, 3));
        end
        @(negedge clk);
        check_bit(commit_valid, 1'b0, "commit_valid once drained");
        finish_test("in_order");
    endtask

    task automatic test_partial_ds();
        rob_idx_t ra;
        rob_idx_t rb;
        test_errs = errors;
        flush_rob();
        send_pair(rand_uop(1'b0, 1'b0), rand_uop(1'b0, 1'b0));
        send_pair(rand_uop(1'b0, 1'b1), rand_uop(1'b1, 1'b0));
        ra = sb_rows[0];
        rb = sb_rows[1];
        // lane 0 alone may go when lane 1 is no delay slot
        pulse_report(0, finish_rep(ra, 1'b0));
        take_commit(2'b01, expected_entry(sb_uop0[ra], ra, 1'b0), '0, 1);
        @(negedge clk);
        check_bit(commit_valid, 1'b0, "commit_valid with lane 1 busy");
        pulse_report(1, finish_rep(ra, 1'b1));
        take_commit(2'b10, '0, expected_entry(sb_uop1[ra], ra, 1'b1), 0);
        // branch waits for its delay slot
        pulse_report(0, finish_rep(rb, 1'b0));
        repeat (4) begin
            @(negedge clk);
            check_bit(commit_valid, 1'b0, "branch held for busy delay slot");
        end
        pulse_report(2, finish_rep(rb, 1'b1));
        take_commit(2'b11, expected_entry(sb_uop0[rb], rb, 1'b0),
                    expected_entry(sb_uop1[rb], rb, 1'b1), 0);
        finish_test("partial_ds");
    endtask

    task automatic test_outcomes();
        fu_report_t rep;
        rob_entry_t e0;
        rob_entry_t e1;
        addr_t      target;
        addr_t      vaddr;
        rob_idx_t   r;
        test_errs = errors;
        flush_rob();
        send_pair(rand_uop(1'b0, 1'b1), rand_uop(1'b1, 1'b0));
        send_pair(rand_uop(1'b0, 1'b0), rand_uop(1'b0, 1'b0));
        r      = sb_rows[0];
        target = addr_t'($urandom) & 32'hffff_fffc;
        vaddr  = addr_t'($urandom);
        rep              = finish_rep(r, 1'b0);
        rep.set_branch   = 1'b1;
        rep.branch_taken = 1'b1;
        rep.branch_addr  = target;
        pulse_report(0, rep);
        // address error on load, from the lsu
        rep           = finish_rep(r, 1'b1);
        rep.set_exc   = 1'b1;
        rep.exception = 5'd4;
        rep.bad_vaddr = vaddr;
        pulse_report(3, rep);
        pulse_report(1, finish_rep(sb_rows[1], 1'b0));
        pulse_report(2, finish_rep(sb_rows[1], 1'b1));
        e0              = expected_entry(sb_uop0[r], r, 1'b0);
        e0.branch_taken = 1'b1;
        e0.branch_addr  = target;
        e1              = expected_entry(sb_uop1[r], r, 1'b1);
        e1.cause_exc    = 1'b1;
        e1.exception    = 5'd4;
        e1.bad_vaddr    = vaddr;
        take_commit(2'b11, e0, e1, 0);
        r = sb_rows[1];
        take_commit(2'b11, expected_entry(sb_uop0[r], r, 1'b0),
                    expected_entry(sb_uop1[r], r, 1'b1), 2);
        finish_test("outcomes");
    endtask

    task automatic test_flush();
        test_errs = errors;
        flush_rob();
        for (int i = 0; i < 3; i++) begin
            send_pair(rand_uop(1'b0, 1'b0), rand_uop(1'b0, 1'b0));
        end
        pulse_report(0, finish_rep(sb_rows[0], 1'b0));
        flush_rob();
        check_bit(dispatch_ready, 1'b1, "dispatch_ready after flush");
        check_bit(commit_valid, 1'b0, "commit_valid after flush");
        check_idx(dispatch_idx, '0, "dispatch_idx after flush");
        send_pair(rand_uop(1'b0, 1'b0), rand_uop(1'b0, 1'b0));
        check_idx(sb_rows[0], '0, "first row after flush");
        finish_test("flush");
    endtask

    initial begin
        void'($urandom(32'h92580b10));
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        test_errs      = 0;
        rst            = 1'b1;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        commit_ready   = 1'b0;
        for (int f = 0; f < `ROB_NUM_FU; f++) begin
            fu_reports[f] = '0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        test_reset();
        test_capacity();
        test_in_order();
        test_partial_ds();
        test_outcomes();
        test_flush();

        $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+hdl
hdl/rob_types_pkg.sv
hdl/rob_port_pkg.sv
hdl/rob_ctrl.sv
hdl/rob_finish_router.sv
hdl/rob_lane_bank.sv
hdl/rob_top.sv
bench/rob_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
